// ==== vlog.f ====
+incdir+verilog
verilog/scan_out_pkg.sv
verilog/sys_ctrl_regs.sv
verilog/osd_overlay.sv
verilog/extra_av_formatter.sv
verilog/fan_led_pwm.sv
verilog/video_out_top.sv
sim/tb_video_out.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video output testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_video_out \
    -o tb_video_out > build.log 2>&1 &&
    ./obj_dir/tb_video_out > sim.log 2>&1 ||
    cat build.log
[ -f sim.log ] && cat sim.log
grep -qx "TESTBENCH PASSED" sim.log && { echo "TESTBENCH PASSED"; exit 0; } ||
    { echo "TESTBENCH FAILED"; exit 1; }

// ==== sim/tb_video_out.sv ====
// Video output testbench
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module tb_video_out;

    localparam int REG_WRITES  = 40;
    localparam int HDMI_PIXELS = 200;
    localparam int VGA_PIXELS  = 100;
    localparam int HOLD_PIXELS = 30;
    // Sum of all test lengths plus margin for reset and settling
    localparam int WATCHDOG_CYCLES = 2 * REG_WRITES + HDMI_PIXELS + 4 * (VGA_PIXELS + 8)
        + 3 * (HOLD_PIXELS + 12) + 2 * (`PWM_PERIOD + 8) + 2000;

    logic                     pclk_out;
    logic                     po_reset_n;
    logic                     ctrl_wr_i;
    logic [`CTRL_W-1:0]       ctrl_wdata_i;
    logic [`CTRL_W-1:0]       ctrl_rdata_o;
    scan_out_pkg::video_px_t  px_i;
    logic                     osd_enable_i;
    scan_out_pkg::osd_color_e osd_color_i;
    scan_out_pkg::video_px_t  hdmitx_o;
    logic                     hdmitx_5v_en_o;
    scan_out_pkg::vga_dac_t   vga_o;
    logic                     vga_oe_o;
    logic                     vga_psave_n_o;
    logic                     fan_pwm_n_o;
    logic                     led_pwm_o;

    scan_out_pkg::video_px_t hdmi_exp_q[$];
    scan_out_pkg::vga_dac_t  vga_exp_q[$];
    int                      error_count = 0;
    int                      test_errs = 0;
    int                      tests_run = 0;
    int                      tests_passed = 0;
    logic [31:0]             rnd;

    video_out_top video_out_top_inst (.*);

    initial begin
        pclk_out = 1'b0;
        forever #4 pclk_out = ~pclk_out;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge pclk_out);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            error_count++;
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_errs) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, error_count - test_errs);
        end
        test_errs = error_count;
    endtask

    function automatic logic [31:0] ctrl_word(input logic [1:0] sel, input logic [1:0] mode,
                                              input logic [3:0] fan, input logic [3:0] led,
                                              input logic power);
        logic [31:0] w;
        w = '0;
        w[0] = power;
        w[19:16] = fan;
        w[23:20] = led;
        w[27:26] = mode;
        w[29:28] = sel;
        return w;
    endfunction

    // Palette of black, blue, yellow and white
    function automatic scan_out_pkg::video_px_t overlay(input scan_out_pkg::video_px_t px,
                                                        input logic [2:0] osd);
        scan_out_pkg::video_px_t res;
        res = px;
        if (osd[0]) begin
            case (osd[2:1])
                2'd0: {res.r, res.g, res.b} = 24'h000000;
                2'd1: {res.r, res.g, res.b} = 24'h0000ff;
                2'd2: {res.r, res.g, res.b} = 24'hffff00;
                default: {res.r, res.g, res.b} = 24'hffffff;
            endcase
        end
        return res;
    endfunction

    function automatic scan_out_pkg::vga_dac_t format_vga(input scan_out_pkg::video_px_t px,
                                                          input logic [1:0] mode);
        scan_out_pkg::vga_dac_t res;
        logic comp;
        comp = ~(px.hsync ^ px.vsync);
        {res.r, res.g, res.b} = {px.r, px.g, px.b};
        case (mode)
            2'd0: {res.hs, res.vs, res.blank_n, res.sync_n} = {px.hsync, px.vsync, px.de, 1'b0};
            2'd1: {res.hs, res.vs, res.blank_n, res.sync_n} = {comp, 1'b1, px.de, 1'b0};
            2'd2: {res.hs, res.vs, res.blank_n, res.sync_n} = {comp, 1'b1, px.de, comp};
            default: {res.hs, res.vs, res.blank_n, res.sync_n} = {comp, 1'b1, 1'b1, comp};
        endcase
        return res;
    endfunction

    task automatic write_ctrl(input logic [31:0] data);
        @(posedge pclk_out);
        ctrl_wr_i    <= 1'b1;
        ctrl_wdata_i <= data;
        @(posedge pclk_out);
        ctrl_wr_i    <= 1'b0;
    endtask

    // Random pixels with HDMI checked 2 cycles later and VGA 3 cycles later
    task automatic run_stream(input int count, input logic use_vga, input logic [1:0] mode);
        scan_out_pkg::video_px_t px;
        scan_out_pkg::video_px_t hx;
        logic [31:0] r;
        hdmi_exp_q.delete();
        vga_exp_q.delete();
        for (int i = 0; i < count; i++) begin
            r = $urandom;
            px = r[26:0];
            r = $urandom;
            @(posedge pclk_out);
            px_i         <= px;
            osd_enable_i <= r[0];
            osd_color_i  <= scan_out_pkg::osd_color_e'(r[2:1]);
            hx = overlay(px, r[2:0]);
            vga_exp_q.push_back(format_vga(hx, mode));
            if (`HDMITX_R_LSB_MASK)
                hx.r[0] = 1'b0;
            hdmi_exp_q.push_back(hx);
            @(negedge pclk_out);
            if (hdmi_exp_q.size() > 2)
                check("hdmitx_o", 64'(hdmi_exp_q.pop_front()), 64'(hdmitx_o));
            if (use_vga) begin
                check("vga_oe_o", 64'(1), 64'(vga_oe_o));
                if (vga_exp_q.size() > 3)
                    check("vga_o", 64'(vga_exp_q.pop_front()), 64'(vga_o));
            end
        end
    endtask

    // Fill the VGA pipe with one pixel and then switch the port away
    task automatic hold_check(input logic [1:0] sel);
        scan_out_pkg::video_px_t px;
        rnd = $urandom;
        px = rnd[26:0];
        write_ctrl(ctrl_word(2'd1, 2'd2, 4'd0, 4'd0, 1'b1));
        @(posedge pclk_out);
        px_i         <= px;
        osd_enable_i <= 1'b0;
        repeat (4) @(posedge pclk_out);
        write_ctrl(ctrl_word(sel, 2'd2, 4'd0, 4'd0, 1'b1));
        for (int i = 0; i < HOLD_PIXELS; i++) begin
            rnd = $urandom;
            @(posedge pclk_out);
            px_i <= rnd[26:0];
            @(negedge pclk_out);
            check("vga_oe_o", 64'(0), 64'(vga_oe_o));
            check("vga_o", 64'(format_vga(px, 2'd2)), 64'(vga_o));
        end
    endtask

    task automatic pwm_window(input logic power);
        int fan_low = 0;
        int led_high = 0;
        rnd = $urandom;
        write_ctrl(ctrl_word(2'd0, 2'd0, rnd[3:0], rnd[7:4], power));
        repeat (2) @(posedge pclk_out);
        repeat (`PWM_PERIOD) begin
            @(negedge pclk_out);
            if (!fan_pwm_n_o)
                fan_low++;
            if (led_pwm_o)
                led_high++;
        end
        check("fan_pwm_n_o low cycles", 64'(power ? int'(rnd[3:0]) * `PWM_PERIOD / 16 : 0),
              64'(fan_low));
        check("led_pwm_o high cycles", 64'(power ? int'(rnd[7:4]) * `PWM_PERIOD / 16 : 0),
              64'(led_high));
    endtask

    initial begin
        rnd = $urandom(43);
        po_reset_n   = 1'b0;
        ctrl_wr_i    = 1'b0;
        ctrl_wdata_i = '0;
        px_i         = '0;
        osd_enable_i = 1'b0;
        osd_color_i  = scan_out_pkg::OSD_BLACK;
        repeat (4) @(posedge pclk_out);
        po_reset_n <= 1'b1;
        @(negedge pclk_out);
        check("ctrl_rdata_o", 64'(0), 64'(ctrl_rdata_o));
        check("hdmitx_5v_en_o", 64'(0), 64'(hdmitx_5v_en_o));
        check("vga_oe_o", 64'(0), 64'(vga_oe_o));
        check("hdmitx_o", 64'(0), 64'(hdmitx_o));
        check("vga_o", 64'(0), 64'(vga_o));
        check("fan_pwm_n_o", 64'(1), 64'(fan_pwm_n_o));
        check("led_pwm_o", 64'(0), 64'(led_pwm_o));
        end_test("reset");
        for (int i = 0; i < REG_WRITES; i++) begin
            rnd = $urandom;
            write_ctrl(rnd);
            @(negedge pclk_out);
            check("ctrl_rdata_o", 64'(rnd), 64'(ctrl_rdata_o));
            check("hdmitx_5v_en_o", 64'(rnd[0]), 64'(hdmitx_5v_en_o));
            check("vga_psave_n_o", 64'(rnd[0]), 64'(vga_psave_n_o));
        end
        end_test("register");
        run_stream(HDMI_PIXELS, 1'b0, 2'd0);
        end_test("hdmi");
        for (int m = 0; m < 4; m++) begin
            write_ctrl(ctrl_word(2'd1, 2'(m), 4'd0, 4'd0, 1'b1));
            repeat (4) @(posedge pclk_out);
            run_stream(VGA_PIXELS, 1'b1, 2'(m));
        end
        end_test("vga modes");
        hold_check(2'd0);
        hold_check(2'd2);
        hold_check(2'd3);
        end_test("vga hold");
        pwm_window(1'b1);
        pwm_window(1'b0);
        end_test("pwm");
        $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/video_out_top.sv ====
// Video output top level
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module video_out_top (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  logic                      ctrl_wr_i,
    input  logic [`CTRL_W-1:0]        ctrl_wdata_i,
    output logic [`CTRL_W-1:0]        ctrl_rdata_o,
    input  scan_out_pkg::video_px_t   px_i,
    input  logic                      osd_enable_i,
    input  scan_out_pkg::osd_color_e  osd_color_i,
    output scan_out_pkg::video_px_t   hdmitx_o,
    output logic                      hdmitx_5v_en_o,
    output scan_out_pkg::vga_dac_t    vga_o,
    output logic                      vga_oe_o,
    output logic                      vga_psave_n_o,
    output logic                      fan_pwm_n_o,
    output logic                      led_pwm_o
);

    scan_out_pkg::sys_ctrl_t ctrl;
    scan_out_pkg::video_px_t px_ovl;

    sys_ctrl_regs sys_ctrl_regs_inst (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .ctrl_wr_i    (ctrl_wr_i),
        .ctrl_wdata_i (ctrl_wdata_i),
        .ctrl_rdata_o (ctrl_rdata_o),
        .ctrl_o       (ctrl)
    );

    osd_overlay osd_overlay_inst (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .px_i         (px_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .px_ovl_o     (px_ovl),
        .hdmitx_o     (hdmitx_o)
    );

    // VGA path taps the overlaid pixel before the HDMI launch register
    extra_av_formatter extra_av_formatter_inst (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .px_i          (px_ovl),
        .ctrl_i        (ctrl),
        .vga_o         (vga_o),
        .vga_oe_o      (vga_oe_o),
        .vga_psave_n_o (vga_psave_n_o)
    );

    fan_led_pwm #(
        .PWM_PERIOD (`PWM_PERIOD)
    ) fan_led_pwm_inst (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .ctrl_i      (ctrl),
        .fan_pwm_n_o (fan_pwm_n_o),
        .led_pwm_o   (led_pwm_o)
    );

    assign hdmitx_5v_en_o = ctrl.poweron;

endmodule

// ==== verilog/fan_led_pwm.sv ====
// Fan and LED PWM
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module fan_led_pwm #(
    parameter int PWM_PERIOD = `PWM_PERIOD
) (
    input  logic                     pclk_out,
    input  logic                     po_reset_n,
    input  scan_out_pkg::sys_ctrl_t  ctrl_i,
    output logic                     fan_pwm_n_o,
    output logic                     led_pwm_o
);

    localparam int CNT_W  = $clog2(PWM_PERIOD);
    localparam int PROD_W = CNT_W + `DUTY_W + 1;
    localparam logic [PROD_W-1:0] PERIOD_W = PROD_W'(PWM_PERIOD);
    localparam logic [CNT_W-1:0]  CNT_LAST = CNT_W'(PWM_PERIOD - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             fan_act;
    logic             led_act;

    // Active length is duty * period / 16
    function automatic logic [CNT_W:0] duty_limit(input logic [`DUTY_W-1:0] duty);
        logic [PROD_W-1:0] prod;
        prod = PROD_W'(duty) * PERIOD_W;
        return prod[CNT_W+`DUTY_W:`DUTY_W];
    endfunction

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt_q <= '0;
        end else if (cnt_q == CNT_LAST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign fan_act = ({1'b0, cnt_q} < duty_limit(ctrl_i.fan_duty));
    assign led_act = ({1'b0, cnt_q} < duty_limit(ctrl_i.led_duty));

    // Both channels dark while power is off
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            fan_pwm_n_o <= 1'b1;
            led_pwm_o   <= 1'b0;
        end else begin
            fan_pwm_n_o <= ~(ctrl_i.poweron & fan_act);
            led_pwm_o   <= ctrl_i.poweron & led_act;
        end
    end

endmodule

// ==== verilog/extra_av_formatter.sv ====
// VGA DAC output formatter
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module extra_av_formatter (
    input  logic                     pclk_out,
    input  logic                     po_reset_n,
    input  scan_out_pkg::video_px_t  px_i,
    input  scan_out_pkg::sys_ctrl_t  ctrl_i,
    output scan_out_pkg::vga_dac_t   vga_o,
    output logic                     vga_oe_o,
    output logic                     vga_psave_n_o
);

    logic en;
    logic csync;

    scan_out_pkg::vga_dac_t pre_next;
    scan_out_pkg::vga_dac_t pre_q;
    scan_out_pkg::vga_dac_t vga_q;

    assign en = (ctrl_i.exp_sel == scan_out_pkg::EXP_EXTRA_OUT);

    // Active low composite sync
    assign csync = ~(px_i.hsync ^ px_i.vsync);

    // RGB passes in every mode and only sync and blank differ
    always_comb begin
        pre_next.r       = px_i.r;
        pre_next.g       = px_i.g;
        pre_next.b       = px_i.b;
        pre_next.hs      = csync;
        pre_next.vs      = 1'b1;
        pre_next.blank_n = px_i.de;
        pre_next.sync_n  = 1'b0;
        case (ctrl_i.extra_out_mode)
            scan_out_pkg::OUT_RGBHV: begin
                pre_next.hs = px_i.hsync;
                pre_next.vs = px_i.vsync;
            end
            scan_out_pkg::OUT_RGBCS: begin
                pre_next.sync_n = 1'b0;
            end
            scan_out_pkg::OUT_RGSB: begin
                pre_next.sync_n = csync;
            end
            scan_out_pkg::OUT_YPBPR: begin
                // Sync on luma with DAC blanking left to the sync level
                pre_next.blank_n = 1'b1;
                pre_next.sync_n  = csync;
            end
            default: begin
                pre_next.sync_n = 1'b0;
            end
        endcase
    end

    // Both stages frozen while the port is used for something else
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pre_q <= '0;
            vga_q <= '0;
        end else if (en) begin
            pre_q <= pre_next;
            vga_q <= pre_q;
        end
    end

    assign vga_o         = vga_q;
    assign vga_oe_o      = en;
    assign vga_psave_n_o = ctrl_i.poweron;

    a_hold_when_off: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        !en |=> $stable(vga_o)
    );

endmodule

// ==== verilog/osd_overlay.sv ====
// OSD overlay and HDMI launch
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module osd_overlay (
    input  logic                      pclk_out,
    input  logic                      po_reset_n,
    input  scan_out_pkg::video_px_t   px_i,
    input  logic                      osd_enable_i,
    input  scan_out_pkg::osd_color_e  osd_color_i,
    output scan_out_pkg::video_px_t   px_ovl_o,
    output scan_out_pkg::video_px_t   hdmitx_o
);

    localparam logic R_LSB_MASK = (`HDMITX_R_LSB_MASK != 0);
    localparam logic [`COLOR_W-1:0] C_ON  = '1;
    localparam logic [`COLOR_W-1:0] C_OFF = '0;

    scan_out_pkg::video_px_t px_osd;
    scan_out_pkg::video_px_t px_launch;
    scan_out_pkg::video_px_t px_ovl_q;
    scan_out_pkg::video_px_t hdmitx_q;

    // Palette replaces RGB only and timing passes as is
    always_comb begin
        px_osd = px_i;
        if (osd_enable_i) begin
            case (osd_color_i)
                scan_out_pkg::OSD_BLACK:  {px_osd.r, px_osd.g, px_osd.b} = {C_OFF, C_OFF, C_OFF};
                scan_out_pkg::OSD_BLUE:   {px_osd.r, px_osd.g, px_osd.b} = {C_OFF, C_OFF, C_ON};
                scan_out_pkg::OSD_YELLOW: {px_osd.r, px_osd.g, px_osd.b} = {C_ON, C_ON, C_OFF};
                scan_out_pkg::OSD_WHITE:  {px_osd.r, px_osd.g, px_osd.b} = {C_ON, C_ON, C_ON};
                default:                  px_osd = px_i;
            endcase
        end
    end

    // Red bit 0 couples into neighbouring traces on some boards
    always_comb begin
        px_launch      = px_ovl_q;
        px_launch.r[0] = px_ovl_q.r[0] & ~R_LSB_MASK;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            px_ovl_q <= '0;
            hdmitx_q <= '0;
        end else begin
            px_ovl_q <= px_osd;
            hdmitx_q <= px_launch;
        end
    end

    assign px_ovl_o = px_ovl_q;
    assign hdmitx_o = hdmitx_q;

endmodule

// ==== verilog/sys_ctrl_regs.sv ====
// System control register
`timescale 1ns/1ps
`include "scan_out_settings.svh"

module sys_ctrl_regs (
    input  logic                     pclk_out,
    input  logic                     po_reset_n,
    input  logic                     ctrl_wr_i,
    input  logic [`CTRL_W-1:0]       ctrl_wdata_i,
    output logic [`CTRL_W-1:0]       ctrl_rdata_o,
    output scan_out_pkg::sys_ctrl_t  ctrl_o
);

    // Field positions in the register
    localparam int POWERON_BIT = 0;
    localparam int FAN_LSB     = 16;
    localparam int LED_LSB     = 20;
    localparam int MODE_LSB    = 26;
    localparam int EXP_LSB     = 28;

    logic [`CTRL_W-1:0] ctrl_q;

    // Host write without stall
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ctrl_q <= '0;
        end else if (ctrl_wr_i) begin
            ctrl_q <= ctrl_wdata_i;
        end
    end

    assign ctrl_rdata_o = ctrl_q;

    always_comb begin
        ctrl_o.poweron  = ctrl_q[POWERON_BIT];
        ctrl_o.fan_duty = ctrl_q[FAN_LSB +: `DUTY_W];
        ctrl_o.led_duty = ctrl_q[LED_LSB +: `DUTY_W];
        ctrl_o.extra_out_mode =
            scan_out_pkg::extra_out_mode_e'(ctrl_q[MODE_LSB +: 2]);
        ctrl_o.exp_sel  = scan_out_pkg::exp_sel_e'(ctrl_q[EXP_LSB +: 2]);
    end

    // An unknown strobe would corrupt every field downstream
    a_wr_known: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        !$isunknown(ctrl_wr_i)
    );

endmodule

// ==== verilog/scan_out_pkg.sv ====
// Scan converter output types
`include "scan_out_settings.svh"

package scan_out_pkg;

    // One pixel with its timing signals
    typedef struct packed {
        logic [`COLOR_W-1:0] r;
        logic [`COLOR_W-1:0] g;
        logic [`COLOR_W-1:0] b;
        logic                hsync;
        logic                vsync;
        logic                de;
    } video_px_t;

    // Expansion port use
    typedef enum logic [1:0] {
        EXP_OFF        = 2'd0,
        EXP_EXTRA_OUT  = 2'd1,
        EXP_LEGACY_IN  = 2'd2,
        EXP_UVC_BRIDGE = 2'd3
    } exp_sel_e;

    typedef enum logic [1:0] {
        OUT_RGBHV = 2'd0,
        OUT_RGBCS = 2'd1,
        OUT_RGSB  = 2'd2,
        OUT_YPBPR = 2'd3
    } extra_out_mode_e;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // Fields of the system control register used by the output logic
    typedef struct packed {
        exp_sel_e            exp_sel;
        extra_out_mode_e     extra_out_mode;
        logic [`DUTY_W-1:0]  led_duty;
        logic [`DUTY_W-1:0]  fan_duty;
        logic                poweron;
    } sys_ctrl_t;

    // Signals towards the VGA DAC
    typedef struct packed {
        logic [`COLOR_W-1:0] r;
        logic [`COLOR_W-1:0] g;
        logic [`COLOR_W-1:0] b;
        logic                hs;
        logic                vs;
        logic                blank_n;
        logic                sync_n;
    } vga_dac_t;

endpackage

// ==== verilog/scan_out_settings.svh ====
// Scan converter output board settings
`ifndef SCAN_OUT_SETTINGS_SVH
`define SCAN_OUT_SETTINGS_SVH

// Bits per colour channel
`define COLOR_W 8

// Fan and LED PWM period in pclk_out cycles
`define PWM_PERIOD 1024
`define DUTY_W 4

// Set to 1 on boards with red LSB crosstalk on the HDMI transmitter bus
`define HDMITX_R_LSB_MASK 1

`define CTRL_W 32

`endif
